/* compile.f */
+incdir+hw
hw/tone_pkg.sv
hw/tone_lut.sv
hw/i2s_tx.sv
hw/tone_axil_regs.sv
hw/note_seg_display.sv
hw/tone_top.sv
verification/tone_tb.sv

/* hw/i2s_tx.sv */
`timescale 1ns/1ps

module i2s_tx
    import tone_pkg::*;
#(
    parameter int sample_width = 16
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] note,
    input  logic [2:0] octave,
    output logic       mclk,
    output logic       bclk,
    output logic       lrclk,
    output logic       sdata
);

    logic [frame_bits-1:0]   clk_div;
    logic [31:0]             shift_reg;
    logic [7:0]              sample_cnt;
    logic [7:0]              cnt_max;
    logic [sample_width-1:0] sample;
    logic                    load_sample;
    logic                    frame_end;
    logic                    bit_shift;

    // Free-running frame divider
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            clk_div <= '0;
        else
            clk_div <= clk_div + 1'b1;
    end

    assign mclk  = clk_div[1];            // clk / 4
    assign bclk  = clk_div[3];            // clk / 16
    assign lrclk = clk_div[frame_bits-1]; // One frame per period

    assign load_sample = &clk_div[frame_bits-2:0]; // Last cycle of each half-frame
    assign frame_end   = &clk_div;
    assign bit_shift   = &clk_div[3:0];            // bclk about to fall

    // One sample step per stereo frame
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            sample_cnt <= 8'd0;
        else if (frame_end)
            sample_cnt <= (sample_cnt == cnt_max) ? 8'd0 : sample_cnt + 8'd1;
    end

    // Left-justified word, sample in the top bits
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            shift_reg <= 32'd0;
        else if (load_sample)
            shift_reg <= {sample, {(32 - sample_width){1'b0}}};
        else if (bit_shift)
            shift_reg <= {shift_reg[30:0], 1'b0};
    end

    assign sdata = shift_reg[31]; // Stable at bclk rise

    tone_lut
    #(
        .sample_width ( sample_width )
    )
    u_tone_lut
    (
        .octave    ( octave     ),
        .note      ( note       ),
        .index     ( sample_cnt ),
        .index_max ( cnt_max    ),
        .sample    ( sample     )
    );

    // A silent note keeps the counter parked at zero
    cnt_parked_on_silence: assert property (
        @(posedge clk) disable iff (reset)
        (sample_cnt == 8'd0 && note >= note_count) |=> (sample_cnt == 8'd0)
    )
    else $error("i2s_tx: sample counter moved while silent");

endmodule

/* hw/note_seg_display.sv */
`timescale 1ns/1ps

module note_seg_display
    import tone_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] note,
    output logic [7:0] segments  // abcdefgh, active low
);

    // Letter per note, dot segment h lit for sharps
    localparam logic [7:0] seg_patterns [0:note_count-1] = '{
        8'b0110_0011, // C
        8'b0110_0010, // C#
        8'b1000_0101, // d
        8'b1000_0100, // d#
        8'b0110_0001, // E
        8'b0111_0001, // F
        8'b0111_0000, // F#
        8'b0100_0011, // G
        8'b0100_0010, // G#
        8'b0001_0001, // A
        8'b0001_0000, // A#
        8'b1100_0001  // b
    };

    localparam logic [7:0] seg_blank = 8'b1111_1111;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            segments <= seg_blank;
        else if (note < note_count)
            segments <= seg_patterns[note];
        else
            segments <= seg_blank; // Silence codes
    end

endmodule

/* hw/note_tables.svh */
// Last table index of one sawtooth period at octave 0 from C up
localparam logic [7:0] base_period [0:11] = '{
    8'd183, // C
    8'd173, // C#
    8'd163, // D
    8'd154, // D#
    8'd145, // E
    8'd137, // F
    8'd129, // F#
    8'd122, // G
    8'd115, // G#
    8'd109, // A
    8'd103, // A#
    8'd97   // B
};

// Sample increment per table entry is 65535 / base_period
localparam logic [15:0] saw_step [0:11] = '{
    16'd358, 16'd378, 16'd402, 16'd425,
    16'd451, 16'd478, 16'd508, 16'd537,
    16'd569, 16'd601, 16'd636, 16'd675
};

/* hw/tone_axil_regs.sv */
`timescale 1ns/1ps

module tone_axil_regs
    import tone_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,

    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,

    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,

    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,

    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    output logic [3:0]  note,
    output logic [2:0]  octave
);

    logic write_accept;
    logic read_accept;
    logic write_hit;
    logic read_hit;

    // Address and data taken together, blocked while a response waits
    assign write_accept = awvalid && wvalid && !bvalid;
    assign read_accept  = arvalid && !rvalid;

    assign awready = write_accept;
    assign wready  = write_accept;
    assign arready = read_accept;

    assign write_hit = (awaddr == ctrl_addr);
    assign read_hit  = (araddr == ctrl_addr);

    // Control register, byte lane 0 only
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            note   <= 4'hf; // Silence
            octave <= 3'd0;
        end
        else if (write_accept && write_hit && wstrb[0])
        begin
            note   <= wdata[3:0];
            octave <= wdata[6:4];
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            bvalid <= 1'b0;
        else if (write_accept)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (write_accept)
            bresp <= write_hit ? axil_resp_okay : axil_resp_slverr;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rvalid <= 1'b0;
        else if (read_accept)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // Unmapped addresses read back as zero
    always_ff @(posedge clk)
    begin
        if (read_accept)
        begin
            rdata <= read_hit ? {25'd0, octave, note} : 32'd0;
            rresp <= read_hit ? axil_resp_okay : axil_resp_slverr;
        end
    end

    // Responses hold with stable payload until taken
    bresp_held: assert property (
        @(posedge clk) disable iff (reset)
        (bvalid && !bready) |=> (bvalid && $stable(bresp))
    )
    else $error("tone_axil_regs: write response dropped before bready");

    rresp_held: assert property (
        @(posedge clk) disable iff (reset)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp))
    )
    else $error("tone_axil_regs: read response dropped before rready");

endmodule

/* hw/tone_lut.sv */
`timescale 1ns/1ps

module tone_lut
    import tone_pkg::*;
#(
    parameter int sample_width = 16
)
(
    input  logic [2:0]              octave,
    input  logic [3:0]              note,
    input  logic [7:0]              index,     // Sample counter
    output logic [7:0]              index_max, // Period end at this octave
    output logic [sample_width-1:0] sample
);

    `include "note_tables.svh"

    logic                    note_valid;
    logic [3:0]              note_sel;
    logic [7:0]              table_index;
    logic [31:0]             product;

    assign note_valid = (note < note_count);
    assign note_sel   = note_valid ? note : 4'd0; // Keeps table reads in range

    // Higher octave skips 2**octave entries per step
    assign table_index = index << octave;

    assign product = 32'(table_index) * 32'(saw_step[note_sel]);

    always_comb
    begin
        if (note_valid)
        begin
            sample    = product[sample_width-1:0];
            index_max = base_period[note_sel] >> octave;
        end
        else
        begin
            sample    = '0;          // Silence
            index_max = 8'd0;
        end
    end

endmodule

/* hw/tone_pkg.sv */
package tone_pkg;

    // Real notes C to B, codes 12 to 15 mean silence
    localparam int note_count = 12;

    // Divider width, one stereo frame is 2**frame_bits clk cycles
    localparam int frame_bits = 10;

    // AXI4-Lite response codes
    localparam logic [1:0] axil_resp_okay   = 2'b00;
    localparam logic [1:0] axil_resp_slverr = 2'b10;

    // Control register byte address
    // Bits 3:0 hold the note, bits 6:4 the octave, the rest read as zero
    localparam logic [3:0] ctrl_addr = 4'h0;

endpackage

/* hw/tone_top.sv */
`timescale 1ns/1ps

module tone_top
#(
    parameter int sample_width = 16
)
(
    input  logic        clk,
    input  logic        reset,

    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    output logic        mclk,
    output logic        bclk,
    output logic        lrclk,
    output logic        sdata,
    output logic [7:0]  segments
);

    logic [3:0] note;
    logic [2:0] octave;

    tone_axil_regs u_regs
    (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .awaddr  ( awaddr  ),
        .awvalid ( awvalid ),
        .awready ( awready ),
        .wdata   ( wdata   ),
        .wstrb   ( wstrb   ),
        .wvalid  ( wvalid  ),
        .wready  ( wready  ),
        .bresp   ( bresp   ),
        .bvalid  ( bvalid  ),
        .bready  ( bready  ),
        .araddr  ( araddr  ),
        .arvalid ( arvalid ),
        .arready ( arready ),
        .rdata   ( rdata   ),
        .rresp   ( rresp   ),
        .rvalid  ( rvalid  ),
        .rready  ( rready  ),
        .note    ( note    ),
        .octave  ( octave  )
    );

    i2s_tx
    #(
        .sample_width ( sample_width )
    )
    u_i2s_tx
    (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .note   ( note   ),
        .octave ( octave ),
        .mclk   ( mclk   ),
        .bclk   ( bclk   ),
        .lrclk  ( lrclk  ),
        .sdata  ( sdata  )
    );

    note_seg_display u_display
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .note     ( note     ),
        .segments ( segments )
    );

endmodule

/* verification/tone_tb.sv */
`timescale 1ns/1ps

module tone_tb
    import tone_pkg::*;
();

    `include "note_tables.svh"

    localparam int sample_width        = 16;
    localparam int scenario_count      = 20;
    localparam int frames_per_scenario = 6;
    localparam int frame_cycles        = 2 ** frame_bits;
    localparam int test_frames         = scenario_count * frames_per_scenario + 8;
    localparam int min_words           = 2 * scenario_count * frames_per_scenario;
    localparam int half_period [0:2]   = '{2, 8, frame_cycles / 2}; // mclk, bclk, lrclk

    logic        clk;
    logic        reset;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        mclk;
    logic        bclk;
    logic        lrclk;
    logic        sdata;
    logic [7:0]  segments;

    logic [frame_bits-1:0] div_model;    // Mirrors the frame divider
    logic [7:0]            cnt_model;
    logic [3:0]            shadow_note;
    logic [2:0]            shadow_oct;
    logic [7:0]            seg_expected;
    logic [31:0]           word_queue [$];
    logic                  lr_queue [$];
    logic [31:0]           rx_word;
    logic [31:0]           exp_word;
    logic                  exp_lr;
    int                    rx_bits       = 0;
    int                    words_checked = 0;
    logic [2:0]            edge_level;
    logic [2:0]            edge_prev;
    logic [2:0]            edge_seen;
    int                    run_len [0:2];
    string                 clock_names [0:2] = '{"mclk", "bclk", "lrclk"};

    tone_top dut
    (
        .clk (clk), .reset (reset),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .mclk (mclk), .bclk (bclk), .lrclk (lrclk), .sdata (sdata),
        .segments (segments)
    );

    always #20 clk = ~clk;

    task automatic stop_with_fail();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        stop_with_fail();
    endtask

    function automatic logic [sample_width-1:0] expected_sample(input logic [3:0] n,
                                                               input logic [2:0] oct,
                                                               input logic [7:0] cnt);
        logic [7:0]  idx;
        logic [31:0] prod;
        if (n >= note_count)
            return '0;                // Silence
        idx  = cnt << oct;            // Octave skips entries and wraps at 8 bits
        prod = idx * saw_step[n];
        return prod[sample_width-1:0];
    endfunction

    function automatic logic [7:0] period_end(input logic [3:0] n, input logic [2:0] oct);
        if (n >= note_count)
            return 8'd0;
        return base_period[n] >> oct;
    endfunction

    // Active-low abcdefgh with the dot lit on sharps
    function automatic logic [7:0] seg_pattern(input logic [3:0] n);
        logic [6:0] lit;
        logic       sharp;
        sharp = (n == 1 || n == 3 || n == 6 || n == 8 || n == 10);
        case (n)
            4'd0, 4'd1:  lit = 7'b1001110; // C
            4'd2, 4'd3:  lit = 7'b0111101; // d
            4'd4:        lit = 7'b1001111; // E
            4'd5, 4'd6:  lit = 7'b1000111; // F
            4'd7, 4'd8:  lit = 7'b1011110; // G
            4'd9, 4'd10: lit = 7'b1110111; // A
            4'd11:       lit = 7'b0011111; // b
            default:     lit = 7'b0000000;
        endcase
        return ~{lit, sharp};
    endfunction

    task automatic write_register(input logic [3:0] addr, input logic [31:0] data,
                                  input logic [3:0] strb, output logic [1:0] resp);
        repeat ($urandom_range(0, 3)) @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        do
            @(posedge clk);
        while (!awready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat ($urandom_range(0, 5)) @(posedge clk); // bready stall
        bready <= 1'b1;
        do
            @(posedge clk);
        while (!bvalid);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic read_register(input logic [3:0] addr, output logic [31:0] data,
                                 output logic [1:0] resp);
        repeat ($urandom_range(0, 3)) @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do
            @(posedge clk);
        while (!arready);
        arvalid <= 1'b0;
        repeat ($urandom_range(0, 5)) @(posedge clk); // rready stall
        rready <= 1'b1;
        do
            @(posedge clk);
        while (!rvalid);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic verify_control_readback(input logic [3:0] n, input logic [2:0] oct);
        logic [31:0] data;
        logic [1:0]  resp;
        read_register(ctrl_addr, data, resp);
        assert (resp == axil_resp_okay && data == {25'd0, oct, n})
        else report_error($sformatf("control read %h resp %b, expected %h resp %b",
                                    data, resp, {25'd0, oct, n}, axil_resp_okay));
    endtask

    // Reference model queues one word at each half-frame load
    always @(posedge clk)
    begin
        if (reset)
        begin
            div_model    = '0;
            cnt_model    = 8'd0;
            shadow_note  = 4'hf;
            shadow_oct   = 3'd0;
            seg_expected = 8'hff;
            word_queue.delete();
            lr_queue.delete();
            word_queue.push_back(32'd0); // First half-frame after reset
            lr_queue.push_back(1'b0);
        end
        else
        begin
            assert (segments === seg_expected)
            else report_error($sformatf("segments %b, expected %b", segments, seg_expected));
            assert (wready === awready)
            else report_error($sformatf("wready %b, expected %b with awready", wready,
                                        awready));
            seg_expected = seg_pattern(shadow_note);
            if (&div_model[frame_bits-2:0])
            begin
                word_queue.push_back({expected_sample(shadow_note, shadow_oct, cnt_model),
                                      {(32 - sample_width){1'b0}}});
                lr_queue.push_back(!div_model[frame_bits-1]);
            end
            if (&div_model)
                cnt_model = (cnt_model == period_end(shadow_note, shadow_oct)) ?
                            8'd0 : cnt_model + 8'd1;
            if (awready && awaddr == ctrl_addr && wstrb[0]) // Takes effect next cycle
            begin
                shadow_note = wdata[3:0];
                shadow_oct  = wdata[6:4];
            end
            div_model = div_model + 1'b1;
        end
    end

    // I2S receiver takes the MSB first
    always @(posedge bclk)
    begin
        rx_word = {rx_word[30:0], sdata};
        rx_bits = rx_bits + 1;
        if (rx_bits == 32)
        begin
            rx_bits = 0;
            assert (word_queue.size() > 0)
            else report_error("received an I2S word that the model did not expect");
            exp_word = word_queue.pop_front();
            exp_lr   = lr_queue.pop_front();
            assert (rx_word === exp_word && lrclk === exp_lr)
            else report_error($sformatf("word %h on lrclk %b, expected %h on lrclk %b",
                                        rx_word, lrclk, exp_word, exp_lr));
            words_checked = words_checked + 1;
        end
    end

    // Clock half-periods counted in clk cycles
    always @(posedge clk)
    begin
        edge_level = {lrclk, bclk, mclk};
        if (reset)
        begin
            edge_seen = 3'b000;
        end
        else
        begin
            for (int k = 0; k < 3; k++)
            begin
                if (edge_level[k] != edge_prev[k])
                begin
                    if (edge_seen[k]) // First run includes reset
                    begin
                        assert (run_len[k] == half_period[k])
                        else report_error($sformatf("%s half-period %0d cycles, expected %0d",
                                                    clock_names[k], run_len[k],
                                                    half_period[k]));
                    end
                    edge_seen[k] = 1'b1;
                    run_len[k]   = 1;
                end
                else
                    run_len[k] = run_len[k] + 1;
            end
        end
        edge_prev = edge_level;
    end

    initial
    begin
        #(longint'(test_frames) * frame_cycles * 40 + 200_000);
        $display("watchdog expired before the test finished");
        stop_with_fail();
    end

    initial
    begin
        logic [1:0]  resp;
        logic [31:0] data;
        logic [3:0]  reg_note;
        logic [2:0]  reg_oct;
        void'($urandom(32'h665b));
        clk      = 1'b0;
        reset    = 1'b1;
        awaddr   = 4'h0;
        awvalid  = 1'b0;
        wdata    = 32'd0;
        wstrb    = 4'h0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = 4'h0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        reg_note = 4'hf;
        reg_oct  = 3'd0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (3 * frame_cycles / 2) @(posedge clk); // Silent words and a blank display
        verify_control_readback(reg_note, reg_oct);

        write_register(4'h4, $urandom, 4'hf, resp);
        assert (resp == axil_resp_slverr)
        else report_error($sformatf("unmapped write resp %b, expected SLVERR", resp));
        read_register(4'h8, data, resp);
        assert (resp == axil_resp_slverr && data == 32'd0)
        else report_error($sformatf("unmapped read %h resp %b, expected 0 SLVERR", data, resp));
        verify_control_readback(reg_note, reg_oct);

        for (int i = 0; i < scenario_count; i++)
        begin
            if (i % 5 == 4)
                reg_note = 4'(12 + $urandom_range(0, 3)); // Silence codes
            else
                reg_note = 4'($urandom_range(0, note_count - 1));
            reg_oct = 3'($urandom_range(0, 7));
            data    = $urandom;
            data[6:0] = {reg_oct, reg_note};
            write_register(ctrl_addr, data, {3'($urandom_range(0, 7)), 1'b1}, resp);
            assert (resp == axil_resp_okay)
            else report_error($sformatf("control write resp %b, expected OKAY", resp));
            verify_control_readback(reg_note, reg_oct);
            if (i % 4 == 1)
            begin
                write_register(4'(4 * $urandom_range(1, 3)), $urandom, 4'hf, resp);
                assert (resp == axil_resp_slverr)
                else report_error($sformatf("unmapped write resp %b, expected SLVERR", resp));
                write_register(ctrl_addr, $urandom, 4'b1110, resp); // Lane 0 disabled
                assert (resp == axil_resp_okay)
                else report_error($sformatf("masked write resp %b, expected OKAY", resp));
                verify_control_readback(reg_note, reg_oct);
            end
            repeat (frames_per_scenario * frame_cycles) @(posedge clk);
        end

        if (words_checked >= min_words)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
        begin
            $display("only %0d I2S words were received", words_checked);
            stop_with_fail();
        end
    end

endmodule
